// ==== Bender.yml ====
package:
  name: lsu

sources:
  # packages first, then the stages and the top level
  - lsu_cfg_pkg.sv
  - lsu_op_pkg.sv
  - lsu_agu.sv
  - lsu_bypass.sv
  - lsu_mem_access.sv
  - lsu_pipe_reg.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu_top.sv

// ==== lsu_agu.sv ====
// address stage of the load/store unit
// address sum, byte enables and misalignment check
`default_nettype none

module lsu_agu (
    input  logic                                 lsu_valid_i,
    input  lsu_op_pkg::lsu_op_e                  lsu_op_i,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         operand_a_i,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         operand_b_i,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         imm_i,
    input  logic [lsu_cfg_pkg::TransIdWidth-1:0] trans_id_i,
    output lsu_op_pkg::lsu_req_t                 req_o
);
    import lsu_cfg_pkg::*;
    import lsu_op_pkg::*;

    logic [Xlen-1:0]       vaddr_full;
    logic [VAddrWidth-1:0] vaddr;
    logic [1:0]            size;
    logic [BeWidth-1:0]    be;
    logic                  misaligned;

    assign vaddr_full = $unsigned($signed(operand_a_i) + $signed(imm_i));
    assign vaddr      = vaddr_full[VAddrWidth-1:0];

    // log2 of the transfer size in bytes
    always_comb begin
        case (lsu_op_i)
            LB, LBU, SB: size = 2'd0;
            LH, LHU, SH: size = 2'd1;
            LW, LWU, SW: size = 2'd2;
            default:     size = 2'd3;
        endcase
    end

    always_comb begin
        case (size)
            2'd0: begin
                be         = 8'h01 << vaddr[2:0];
                misaligned = 1'b0;
            end
            2'd1: begin
                be         = 8'h03 << vaddr[2:0];
                misaligned = vaddr[0];
            end
            2'd2: begin
                be         = 8'h0f << vaddr[2:0];
                misaligned = |vaddr[1:0];
            end
            default: begin
                be         = 8'hff;
                misaligned = |vaddr[2:0];
            end
        endcase
    end

    always_comb begin
        req_o          = '0;
        req_o.valid    = lsu_valid_i;
        req_o.vaddr    = vaddr;
        req_o.data     = operand_b_i;
        req_o.be       = be;
        req_o.op       = lsu_op_i;
        req_o.trans_id = trans_id_i;
        // the memory stage only passes this exception on
        if (lsu_valid_i && misaligned) begin
            req_o.exc.valid = 1'b1;
            req_o.exc.tval  = vaddr;
            if (is_store(lsu_op_i)) begin
                req_o.exc.cause = ST_ADDR_MISALIGNED;
            end else begin
                req_o.exc.cause = LD_ADDR_MISALIGNED;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsu_bypass.sv ====
// two-entry request buffer in front of the memory stage
// the incoming request bypasses it while it is empty
`default_nettype none

module lsu_bypass (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  lsu_op_pkg::lsu_req_t req_i,
    input  logic                 pop_i,
    output lsu_op_pkg::lsu_req_t head_o,
    output logic                 ready_o
);
    import lsu_op_pkg::*;

    lsu_req_t   mem_q [2];
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] cnt_q;
    logic       empty;
    logic       push;
    logic       pop_head;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;
    assign head_o  = empty ? req_i : mem_q[rd_ptr_q];

    // a request that completes in its own cycle never enters the buffer
    assign push     = req_i.valid && !(empty && pop_i);
    assign pop_head = pop_i && !empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop_head) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            case ({push, pop_head})
                2'b10:   cnt_q <= cnt_q + 2'd1;
                2'b01:   cnt_q <= cnt_q - 2'd1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
        // invalidate the popped head
        if (pop_head) begin
            mem_q[rd_ptr_q].valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_cfg_pkg.sv ====
// widths and sizes of the load/store unit
// data path, virtual address, scoreboard id and Wishbone bus
`default_nettype none

package lsu_cfg_pkg;

    // data path
    localparam int unsigned Xlen         = 64;
    localparam int unsigned VAddrWidth   = 32;
    localparam int unsigned TransIdWidth = 3;

    // one 64-bit word per Wishbone beat
    localparam int unsigned BeWidth      = Xlen / 8;
    localparam int unsigned WbAdrWidth   = VAddrWidth - 3;

endpackage

`default_nettype wire

// ==== lsu_mem_access.sv ====
// memory-access stage of the load/store unit
// Wishbone classic master, one bus cycle per aligned request
// store lane alignment, load shift and sign/zero extension
`default_nettype none

module lsu_mem_access (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  lsu_op_pkg::lsu_req_t               head_i,
    output logic                               pop_o,
    // Wishbone master
    output logic                               wb_cyc_o,
    output logic                               wb_stb_o,
    output logic                               wb_we_o,
    output logic [lsu_cfg_pkg::WbAdrWidth-1:0] wb_adr_o,
    output logic [lsu_cfg_pkg::BeWidth-1:0]    wb_sel_o,
    output logic [lsu_cfg_pkg::Xlen-1:0]       wb_dat_o,
    input  logic [lsu_cfg_pkg::Xlen-1:0]       wb_dat_i,
    input  logic                               wb_ack_i,
    input  logic                               wb_err_i,
    // results
    output lsu_op_pkg::load_result_t           load_res_o,
    output lsu_op_pkg::store_result_t          store_res_o
);
    import lsu_cfg_pkg::*;
    import lsu_op_pkg::*;

    // gap holds cyc low for one cycle after ack or err
    typedef enum logic [1:0] {Idle, Bus, Gap} state_e;

    state_e          state_q;
    state_e          state_d;
    logic            is_st;
    logic            bus_done;
    logic [5:0]      shamt;
    logic [Xlen-1:0] rdata;
    logic [Xlen-1:0] ld_data;
    lsu_exc_t        exc;

    assign is_st = is_store(head_i.op);
    assign shamt = {head_i.vaddr[2:0], 3'b000};

    // bus outputs follow the head, which stays stable during wait states
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = is_st;
    assign wb_adr_o = head_i.vaddr[VAddrWidth-1:3];
    assign wb_sel_o = head_i.be;
    assign wb_dat_o = head_i.data << shamt;

    // --------------------------------------------------
    // bus FSM
    // --------------------------------------------------
    always_comb begin
        state_d  = state_q;
        wb_cyc_o = 1'b0;
        pop_o    = 1'b0;
        case (state_q)
            Bus: begin
                wb_cyc_o = 1'b1;
            end
            default: begin
                state_d = Idle;
                if (head_i.valid) begin
                    if (head_i.exc.valid) begin
                        // complete at once without a bus cycle
                        pop_o = 1'b1;
                    end else if (state_q == Idle) begin
                        wb_cyc_o = 1'b1;
                        state_d  = Bus;
                    end
                end
            end
        endcase
        bus_done = wb_cyc_o && (wb_ack_i || wb_err_i);
        if (bus_done) begin
            pop_o   = 1'b1;
            state_d = Gap;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Idle;
        end else begin
            state_q <= state_d;
        end
    end

    // load data down to bit 0, then extend
    assign rdata = wb_dat_i >> shamt;

    always_comb begin
        case (head_i.op)
            LB:      ld_data = {{(Xlen-8){rdata[7]}}, rdata[7:0]};
            LBU:     ld_data = {{(Xlen-8){1'b0}}, rdata[7:0]};
            LH:      ld_data = {{(Xlen-16){rdata[15]}}, rdata[15:0]};
            LHU:     ld_data = {{(Xlen-16){1'b0}}, rdata[15:0]};
            LW:      ld_data = {{(Xlen-32){rdata[31]}}, rdata[31:0]};
            LWU:     ld_data = {{(Xlen-32){1'b0}}, rdata[31:0]};
            default: ld_data = rdata;
        endcase
    end

    // bus error turns into an access fault
    always_comb begin
        exc = head_i.exc;
        if (bus_done && wb_err_i) begin
            exc.valid = 1'b1;
            exc.tval  = head_i.vaddr;
            if (is_st) begin
                exc.cause = ST_ACCESS_FAULT;
            end else begin
                exc.cause = LD_ACCESS_FAULT;
            end
        end
    end

    always_comb begin
        load_res_o           = '0;
        load_res_o.valid     = pop_o && !is_st;
        load_res_o.trans_id  = head_i.trans_id;
        load_res_o.exc       = exc;
        if (!exc.valid) begin
            load_res_o.data = ld_data;
        end
        store_res_o          = '0;
        store_res_o.valid    = pop_o && is_st;
        store_res_o.trans_id = head_i.trans_id;
        store_res_o.exc      = exc;
    end

endmodule

`default_nettype wire

// ==== lsu_op_pkg.sv ====
// operation encoding and exception causes of the load/store unit
// request type held in the buffer, load and store result types
`default_nettype none

package lsu_op_pkg;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU,
        LW, LWU, LD,
        SB, SH, SW, SD
    } lsu_op_e;

    // subset of the RISC-V exception codes
    typedef enum logic [3:0] {
        EXC_NONE           = 4'd0,
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } exc_cause_e;

    typedef struct packed {
        logic                                valid;
        exc_cause_e                          cause;
        logic [lsu_cfg_pkg::VAddrWidth-1:0]  tval;
    } lsu_exc_t;

    // --------------------------------------------------
    // request and results
    // --------------------------------------------------
    typedef struct packed {
        logic                                valid;
        logic [lsu_cfg_pkg::VAddrWidth-1:0]  vaddr;
        logic [lsu_cfg_pkg::Xlen-1:0]        data;
        logic [lsu_cfg_pkg::BeWidth-1:0]     be;
        lsu_op_e                             op;
        logic [lsu_cfg_pkg::TransIdWidth-1:0] trans_id;
        lsu_exc_t                            exc;
    } lsu_req_t;

    typedef struct packed {
        logic                                valid;
        logic [lsu_cfg_pkg::TransIdWidth-1:0] trans_id;
        logic [lsu_cfg_pkg::Xlen-1:0]        data;
        lsu_exc_t                            exc;
    } load_result_t;

    typedef struct packed {
        logic                                valid;
        logic [lsu_cfg_pkg::TransIdWidth-1:0] trans_id;
        lsu_exc_t                            exc;
    } store_result_t;

    function automatic logic is_store(lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

endpackage

`default_nettype wire

// ==== lsu_pipe_reg.sv ====
// result pipe register of Depth stages for any payload type
`default_nettype none

module lsu_pipe_reg #(
    parameter type         payload_t = logic,
    parameter int unsigned Depth     = 1
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  payload_t d_i,
    output payload_t d_o
);

    payload_t stage_q [Depth];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned i = 0; i < Depth; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            // shift towards the output
            for (int unsigned i = 1; i < Depth; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign d_o = stage_q[Depth-1];

endmodule

`default_nettype wire

// ==== lsu_stim.txt ====
# name op operand_a imm operand_b trans_id exp_result exp_exc_valid exp_cause
# all numbers in hex, exp_result is compared for loads without an exception
sd_init   SD  100      0                0123456789abcdef 0 0                0 0
ld_init   LD  100      0                0                1 0123456789abcdef 0 0
sb_lane3  SB  100      3                ffffffffffffffa5 2 0                0 0
ld_lane3  LD  100      0                0                3 01234567a5abcdef 0 0
lb_neg    LB  108      fffffffffffffffb 0                4 ffffffffffffffa5 0 0
lbu_pos   LBU 100      3                0                5 a5               0 0
sh_hi     SH  110      2                ffffffffffff8001 6 0                0 0
lh_sext   LH  110      2                0                7 ffffffffffff8001 0 0
lhu_zext  LHU 112      0                0                0 8001             0 0
sw_hi     SW  120      4                0000000080000010 1 0                0 0
lw_sext   LW  124      0                0                2 ffffffff80000010 0 0
lwu_zext  LWU 120      4                0                3 80000010         0 0
ld_word   LD  120      0                0                4 8000001000000000 0 0
sd_pat    SD  130      0                8877665544332211 5 0                0 0
lbu_b0    LBU 130      0                0                6 11               0 0
lh_b6     LH  130      6                0                7 ffffffffffff8877 0 0
lh_mis    LH  101      0                0                0 0                1 4
sw_mis    SW  100      2                11               1 0                1 6
ld_mis    LD  104      0                0                2 0                1 4
sd_mis    SD  108      4                22               3 0                1 6
lw_fault  LW  80000000 10               0                4 0                1 5
sb_fault  SB  80000000 1                33               5 0                1 7
ld_after  LD  130      0                0                6 8877665544332211 0 0

// ==== lsu_top.f ====
lsu_cfg_pkg.sv
lsu_op_pkg.sv
lsu_agu.sv
lsu_bypass.sv
lsu_mem_access.sv
lsu_pipe_reg.sv
lsu_top.sv
tb_lsu_top.sv

// ==== lsu_top.sv ====
// load/store unit top level
// address stage, request buffer, Wishbone memory stage, result pipes
`default_nettype none

module lsu_top #(
    parameter int unsigned NrLoadPipeRegs  = 1,
    parameter int unsigned NrStorePipeRegs = 1
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // request
    input  logic                                 lsu_valid_i,
    input  lsu_op_pkg::lsu_op_e                  lsu_op_i,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         operand_a_i,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         operand_b_i,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         imm_i,
    input  logic [lsu_cfg_pkg::TransIdWidth-1:0] trans_id_i,
    output logic                                 lsu_ready_o,
    // load results
    output logic                                 load_valid_o,
    output logic [lsu_cfg_pkg::TransIdWidth-1:0] load_trans_id_o,
    output logic [lsu_cfg_pkg::Xlen-1:0]         load_result_o,
    output logic                                 load_exc_valid_o,
    output lsu_op_pkg::exc_cause_e               load_exc_cause_o,
    output logic [lsu_cfg_pkg::VAddrWidth-1:0]   load_exc_tval_o,
    // store results
    output logic                                 store_valid_o,
    output logic [lsu_cfg_pkg::TransIdWidth-1:0] store_trans_id_o,
    output logic                                 store_exc_valid_o,
    output lsu_op_pkg::exc_cause_e               store_exc_cause_o,
    output logic [lsu_cfg_pkg::VAddrWidth-1:0]   store_exc_tval_o,
    // Wishbone master
    output logic                                 wb_cyc_o,
    output logic                                 wb_stb_o,
    output logic                                 wb_we_o,
    output logic [lsu_cfg_pkg::WbAdrWidth-1:0]   wb_adr_o,
    output logic [lsu_cfg_pkg::BeWidth-1:0]      wb_sel_o,
    output logic [lsu_cfg_pkg::Xlen-1:0]         wb_dat_o,
    input  logic [lsu_cfg_pkg::Xlen-1:0]         wb_dat_i,
    input  logic                                 wb_ack_i,
    input  logic                                 wb_err_i
);
    import lsu_op_pkg::*;

    lsu_req_t      new_req;
    lsu_req_t      head;
    logic          pop;
    load_result_t  ld_res;
    load_result_t  ld_res_q;
    store_result_t st_res;
    store_result_t st_res_q;

    lsu_agu i_agu (
        .lsu_valid_i (lsu_valid_i),
        .lsu_op_i    (lsu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .trans_id_i  (trans_id_i),
        .req_o       (new_req)
    );

    lsu_bypass i_bypass (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (new_req),
        .pop_i   (pop),
        .head_o  (head),
        .ready_o (lsu_ready_o)
    );

    lsu_mem_access i_mem_access (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .head_i      (head),
        .pop_o       (pop),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_o    (wb_dat_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .wb_err_i    (wb_err_i),
        .load_res_o  (ld_res),
        .store_res_o (st_res)
    );

    // --------------------------------------------------
    // output pipe registers
    // --------------------------------------------------
    lsu_pipe_reg #(
        .payload_t (load_result_t),
        .Depth     (NrLoadPipeRegs)
    ) i_load_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (ld_res),
        .d_o    (ld_res_q)
    );

    lsu_pipe_reg #(
        .payload_t (store_result_t),
        .Depth     (NrStorePipeRegs)
    ) i_store_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (st_res),
        .d_o    (st_res_q)
    );

    assign load_valid_o      = ld_res_q.valid;
    assign load_trans_id_o   = ld_res_q.trans_id;
    assign load_result_o     = ld_res_q.data;
    assign load_exc_valid_o  = ld_res_q.exc.valid;
    assign load_exc_cause_o  = ld_res_q.exc.cause;
    assign load_exc_tval_o   = ld_res_q.exc.tval;

    assign store_valid_o     = st_res_q.valid;
    assign store_trans_id_o  = st_res_q.trans_id;
    assign store_exc_valid_o = st_res_q.exc.valid;
    assign store_exc_cause_o = st_res_q.exc.cause;
    assign store_exc_tval_o  = st_res_q.exc.tval;

endmodule

`default_nettype wire

// ==== tb_lsu_top.sv ====
// testbench of the load/store unit
// Wishbone memory model with random wait states, stimulus file reader,
// result checks against queues of expected values, cycle timeout
`default_nettype none

module tb_lsu_top;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_op_pkg::*;

    localparam int unsigned MemWords = 256;

    logic        clk_i;
    logic        rst_ni;
    logic        lsu_valid_i;
    lsu_op_e     lsu_op_i;
    logic [63:0] operand_a_i;
    logic [63:0] operand_b_i;
    logic [63:0] imm_i;
    logic [2:0]  trans_id_i;
    logic        lsu_ready_o;
    logic        load_valid_o;
    logic [2:0]  load_trans_id_o;
    logic [63:0] load_result_o;
    logic        load_exc_valid_o;
    exc_cause_e  load_exc_cause_o;
    logic [31:0] load_exc_tval_o;
    logic        store_valid_o;
    logic [2:0]  store_trans_id_o;
    logic        store_exc_valid_o;
    exc_cause_e  store_exc_cause_o;
    logic [31:0] store_exc_tval_o;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic        wb_we_o;
    logic [28:0] wb_adr_o;
    logic [7:0]  wb_sel_o;
    logic [63:0] wb_dat_o;
    logic [63:0] wb_dat_i;
    logic        wb_ack_i;
    logic        wb_err_i;

    // one entry per test in file order
    string       t_name  [$];
    lsu_op_e     t_op    [$];
    logic        t_store [$];
    logic [63:0] t_a     [$];
    logic [63:0] t_imm   [$];
    logic [63:0] t_b     [$];
    logic [63:0] t_tid   [$];
    logic [63:0] t_res   [$];
    logic [63:0] t_exc   [$];
    logic [63:0] t_cause [$];

    // indices of outstanding tests
    int          load_q  [$];
    int          store_q [$];

    logic [63:0] mem [MemWords];
    logic [16:0] lfsr_state = 17'd73365;
    int          pass_cnt;
    int          fail_cnt;
    int          other_errs;
    int          bus_cycles;
    int          exp_bus_cycles;
    int          timeout_limit;

    lsu_top #(
        .NrLoadPipeRegs  (2),
        .NrStorePipeRegs (1)
    ) i_dut (.*);

    initial begin : clock
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // x^17 + x^14 + 1 feedback
    // one shift per random bit
    function automatic logic next_rand_bit();
        logic fb;
        fb         = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    function automatic logic [1:0] draw_wait();
        logic [1:0] w;
        w[1] = next_rand_bit();
        w[0] = next_rand_bit();
        return w;
    endfunction

    function automatic lsu_op_e op_from_name(input string s, output bit found);
        lsu_op_e op;
        op    = op.first();
        found = 1'b0;
        for (int i = 0; i < op.num(); i++) begin
            if (op.name() == s) begin
                found = 1'b1;
                return op;
            end
            op = op.next();
        end
        return op;
    endfunction

    task automatic read_stimulus();
        int          fd;
        int          n;
        bit          found;
        string       line;
        string       name;
        string       op_name;
        logic [63:0] f [7];
        fd = $fopen("lsu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file lsu_stim.txt");
            other_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", name, op_name,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n != 9) begin
                $display("malformed stimulus line: %s", line);
                other_errs++;
                continue;
            end
            t_name.push_back(name);
            t_op.push_back(op_from_name(op_name, found));
            if (!found) begin
                $display("unknown operation %s in test %s", op_name, name);
                other_errs++;
            end
            t_store.push_back(op_name.substr(0, 0) == "S");
            t_a.push_back(f[0]);
            t_imm.push_back(f[1]);
            t_b.push_back(f[2]);
            t_tid.push_back(f[3]);
            t_res.push_back(f[4]);
            t_exc.push_back(f[5]);
            t_cause.push_back(f[6]);
            // misaligned requests never reach the bus
            if (f[5] == 0 || f[6] == 5 || f[6] == 7) begin
                exp_bus_cycles++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [63:0] exp, input logic [63:0] act,
                               inout bit ok);
        assert (act === exp) else begin
            $display("Error: %s %s expected 0x%0h actual 0x%0h", test, field, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_result(input int idx, input logic [2:0] tid,
                                input logic exc_valid, input logic [3:0] cause,
                                input logic [31:0] tval, input logic [63:0] data);
        bit          ok;
        logic [63:0] addr;
        ok   = 1'b1;
        addr = t_a[idx] + t_imm[idx];
        check_field(t_name[idx], "trans_id", t_tid[idx], tid, ok);
        check_field(t_name[idx], "exc_valid", t_exc[idx], exc_valid, ok);
        if (t_exc[idx] != 0) begin
            check_field(t_name[idx], "cause", t_cause[idx], cause, ok);
            check_field(t_name[idx], "tval", addr[31:0], tval, ok);
        end else if (!t_store[idx]) begin
            check_field(t_name[idx], "data", t_res[idx], data, ok);
        end
        if (ok) begin
            pass_cnt++;
            $display("test %-10s ok", t_name[idx]);
        end else begin
            fail_cnt++;
            $display("test %-10s FAILED", t_name[idx]);
        end
    endtask

    // --------------------------------------------------
    // Wishbone slave that answers err for address bit 31
    // --------------------------------------------------
    always @(posedge clk_i) begin : wb_slave
        logic       in_cycle;
        logic [1:0] wait_left;
        int         idx;
        if (!rst_ni || wb_ack_i || wb_err_i) begin
            wb_ack_i <= 1'b0;
            wb_err_i <= 1'b0;
            in_cycle = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = draw_wait();
            end
            if (wait_left != 0) begin
                wait_left--;
            end else begin
                bus_cycles++;
                idx = wb_adr_o[7:0];
                if (wb_adr_o[28]) begin
                    wb_err_i <= 1'b1;
                end else if (wb_we_o) begin
                    for (int i = 0; i < 8; i++) begin
                        if (wb_sel_o[i]) begin
                            mem[idx][8*i +: 8] = wb_dat_o[8*i +: 8];
                        end
                    end
                    wb_ack_i <= 1'b1;
                end else begin
                    wb_dat_i <= mem[idx];
                    wb_ack_i <= 1'b1;
                end
            end
        end
    end

    always @(posedge clk_i) begin : load_monitor
        int idx;
        if (rst_ni && load_valid_o) begin
            assert (load_q.size() != 0) else begin
                $display("load result arrived with no load outstanding");
                other_errs++;
            end
            if (load_q.size() != 0) begin
                idx = load_q.pop_front();
                check_result(idx, load_trans_id_o, load_exc_valid_o, load_exc_cause_o,
                             load_exc_tval_o, load_result_o);
            end
        end
    end

    always @(posedge clk_i) begin : store_monitor
        int idx;
        if (rst_ni && store_valid_o) begin
            assert (store_q.size() != 0) else begin
                $display("store result arrived with no store outstanding");
                other_errs++;
            end
            if (store_q.size() != 0) begin
                idx = store_q.pop_front();
                check_result(idx, store_trans_id_o, store_exc_valid_o, store_exc_cause_o,
                             store_exc_tval_o, 64'd0);
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge rst_ni);
        while (cycles < timeout_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles, results are still missing", cycles);
        $display("Test failures found");
        $finish;
    end

    // --------------------------------------------------
    // reset, stimulus and final summary
    // --------------------------------------------------
    initial begin : main
        int idx;
        rst_ni      = 1'b0;
        lsu_valid_i = 1'b0;
        lsu_op_i    = LB;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        trans_id_i  = '0;
        wb_dat_i    = '0;
        wb_ack_i    = 1'b0;
        wb_err_i    = 1'b0;
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        read_stimulus();
        timeout_limit = t_name.size() * 8 + 50;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        assert (!wb_cyc_o && !load_valid_o && !store_valid_o && lsu_ready_o) else begin
            $display("DUT outputs are not in their reset state after reset");
            other_errs++;
        end
        // ready seen in an idle cycle stays high in the next one
        idx = 0;
        while (idx < t_name.size()) begin
            @(posedge clk_i);
            if (lsu_valid_i) begin
                lsu_valid_i <= 1'b0;
            end else if (lsu_ready_o) begin
                lsu_valid_i <= 1'b1;
                lsu_op_i    <= t_op[idx];
                operand_a_i <= t_a[idx];
                imm_i       <= t_imm[idx];
                operand_b_i <= t_b[idx];
                trans_id_i  <= t_tid[idx][2:0];
                if (t_store[idx]) begin
                    store_q.push_back(idx);
                end else begin
                    load_q.push_back(idx);
                end
                idx++;
            end
        end
        @(posedge clk_i);
        lsu_valid_i <= 1'b0;
        while (load_q.size() != 0 || store_q.size() != 0) begin
            @(posedge clk_i);
        end
        assert (bus_cycles == exp_bus_cycles) else begin
            $display("the slave saw %0d bus cycles where %0d were due",
                     bus_cycles, exp_bus_cycles);
            other_errs++;
        end
        $display("%0d tests: %0d ok, %0d failed, %0d other errors",
                 t_name.size(), pass_cnt, fail_cnt, other_errs);
        if (fail_cnt == 0 && other_errs == 0 && t_name.size() != 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
